// ==== flist.f ====
src/spi_ctrl_pkg.sv
src/spi_slave_port.sv
src/ctrl_reg_file.sv
src/periph_select.sv
src/bus_response_mux.sv
src/spi_ctrl_top.sv
bench/spi_ctrl_checker.sv
bench/spi_ctrl_tb.sv

// ==== bench/spi_ctrl_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the spi board-control block
// clock, reset, spi host driver, directed tests, timeout
////////////////////////////////////////////////////////////

module spi_ctrl_tb
  import spi_ctrl_pkg::*;
();

  localparam int NUM_PERIPH  = 5;
  localparam int SYNC_STAGES = 2;
  localparam int HALF_SCK    = 4;
  // 67 frames of about 140 cycles, 12 and 20 bit frames together cost two
  localparam int NUM_FRAMES  = 67;
  localparam int CYCLE_LIMIT = NUM_FRAMES * 140 + 500;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  sck;
  logic                  cs_n;
  logic                  mosi;
  logic                  cs2_n;
  logic [NUM_PERIPH-1:0] periph_miso;
  logic                  miso;
  logic [NUM_PERIPH-1:0] periph_cs_n;
  ctrl_nib_t             led;
  ctrl_nib_t             dac_ctrl;
  ctrl_nib_t             adc_ctrl;

  // host-side view of the registers
  ctrl_nib_t   m_led;
  ctrl_nib_t   m_dac;
  ctrl_nib_t   m_adc;
  logic [7:0]  m_sel;
  logic [31:0] lfsr = 32'h18a0;
  string       test_name;
  int          tests = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          cycles = 0;
  int          asserts = 0;

  always #20 clk = ~clk;

  spi_ctrl_top #(
    .NUM_PERIPH  (NUM_PERIPH),
    .SYNC_STAGES (SYNC_STAGES)
  ) spi_ctrl_top_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .adc_ctrl    (adc_ctrl)
  );

  bind spi_ctrl_top spi_ctrl_checker #(
    .NUM_PERIPH (NUM_PERIPH)
  ) spi_ctrl_checker_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame_valid (frame_valid),
    .sel         (sel),
    .cs2_n       (cs2_n),
    .periph_cs_n (periph_cs_n)
  );

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout, run still going after %0d clk cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // models and helpers

  // galois lfsr, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb)
      s = s ^ 32'h8020_0003;
    return s;
  endfunction

  // one lfsr step per bit
  task automatic rand_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  // per bit: set and clear together toggle, otherwise set raises, clear drops
  function automatic ctrl_nib_t next_nib(ctrl_nib_t cur, logic [7:0] value);
    ctrl_nib_t nxt;
    nxt = cur;
    for (int b = 0; b < 4; b++)
    begin
      if (value[b] && value[b+4])
        nxt[b] = ~cur[b];
      else if (value[b])
        nxt[b] = 1'b1;
      else if (value[b+4])
        nxt[b] = 1'b0;
    end
    return nxt;
  endfunction

  // mux value n picks peripheral n-1
  function automatic logic [7:0] sel_of(logic [7:0] n);
    if (n >= 1 && n <= NUM_PERIPH)
      return 8'd1 << (n - 1);
    return 8'd0;
  endfunction

  function automatic logic [7:0] reply_of(logic [7:0] addr);
    case (addr)
      ADDR_LED: return {4'h0, m_led};
      ADDR_DAC: return {4'h0, m_dac};
      ADDR_ADC: return {4'h0, m_adc};
      ADDR_MUX: return m_sel;
      default:  return 8'h00;
    endcase
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] value);
    case (addr)
      ADDR_LED: m_led = next_nib(m_led, value);
      ADDR_DAC: m_dac = next_nib(m_dac, value);
      ADDR_ADC: m_adc = next_nib(m_adc, value);
      ADDR_MUX: m_sel = sel_of(value);
      ADDR_SOFT_RST:
      begin
        m_led = '0;
        m_dac = '0;
        m_adc = '0;
        m_sel = '0;
      end
      ADDR_PWRUP:
      begin
        m_led = '0;
        m_adc = '0;
      end
      default:
      begin
      end
    endcase
  endtask

  task automatic mismatch(input string what, input int exp, input int act);
    test_errors++;
    $display("FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
  endtask

  // mode 0 host, mosi set in the low phase, miso taken just before each rise
  task automatic spi_xfer(input logic [31:0] word, input int nbits, output logic [7:0] rx);
    rx   = '0;
    cs_n = 1'b0;
    repeat (2) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      mosi = word[nbits-1-i];
      repeat (HALF_SCK) @(negedge clk);
      // second byte carries the reply
      if (i >= 8 && i < 16)
        rx = {rx[6:0], miso};
      sck = 1'b1;
      repeat (HALF_SCK) @(negedge clk);
      sck = 1'b0;
    end
    repeat (HALF_SCK) @(negedge clk);
    cs_n = 1'b1;
    // strobe within SYNC_STAGES+2, registers a clock later
    repeat (SYNC_STAGES + 4) @(negedge clk);
  endtask

  // full frame, reply holds the register before this write
  task automatic send(input logic [7:0] addr, input logic [7:0] value);
    logic [7:0] exp;
    logic [7:0] rx;
    exp = reply_of(addr);
    spi_xfer({16'h0000, addr, value}, 16, rx);
    if (rx !== exp)
      mismatch($sformatf("reply at addr %0h", addr), exp, rx);
    model_write(addr, value);
  endtask

  task automatic check_pins(input string what);
    logic [NUM_PERIPH-1:0] exp_cs;
    exp_cs = cs2_n ? '1 : ~m_sel[NUM_PERIPH-1:0];
    if (led !== m_led)
      mismatch({what, " led"}, m_led, led);
    if (dac_ctrl !== m_dac)
      mismatch({what, " dac_ctrl"}, m_dac, dac_ctrl);
    if (adc_ctrl !== m_adc)
      mismatch({what, " adc_ctrl"}, m_adc, adc_ctrl);
    if (periph_cs_n !== exp_cs)
      mismatch({what, " periph_cs_n"}, exp_cs, periph_cs_n);
  endtask

  task automatic end_test();
    tests++;
    if (test_errors == 0)
      $display("test %-18s ok", test_name);
    else
      $display("test %-18s %0d errors", test_name, test_errors);
    errors      += test_errors;
    test_errors  = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic set_clear_toggle();
    logic [7:0] v;
    logic [7:0] addrs [3];
    addrs     = '{ADDR_LED, ADDR_DAC, ADDR_ADC};
    test_name = "set_clear_toggle";
    check_pins("out of reset");
    for (int i = 0; i < 8; i++)
    begin
      for (int j = 0; j < 3; j++)
      begin
        rand_bits(8, v);
        send(addrs[j], v);
        check_pins($sformatf("write %0h", v));
      end
    end
    // value 0 neither sets nor clears, pure readback
    for (int j = 0; j < 3; j++)
      send(addrs[j], 8'h00);
    end_test();
  endtask

  task automatic reset_commands();
    test_name = "reset_commands";
    send(ADDR_LED, 8'h0F);
    send(ADDR_DAC, 8'h05);
    send(ADDR_ADC, 8'h0A);
    send(ADDR_MUX, 8'd3);
    send(ADDR_SOFT_RST, 8'hFF);
    check_pins("after soft reset");
    send(ADDR_MUX, 8'h00);
    send(ADDR_LED, 8'h0F);
    send(ADDR_DAC, 8'h05);
    send(ADDR_ADC, 8'h0A);
    send(ADDR_MUX, 8'd3);
    send(ADDR_PWRUP, 8'hFF);
    check_pins("after power-up clear");
    if (dac_ctrl !== 4'h5)
      mismatch("dac kept by power-up clear", 4'h5, dac_ctrl);
    // select survives, visible in readback and chip selects
    send(ADDR_MUX, 8'd3);
    cs2_n = 1'b0;
    @(negedge clk);
    check_pins("select after power-up clear");
    cs2_n = 1'b1;
    @(negedge clk);
    end_test();
  endtask

  task automatic periph_selection();
    test_name = "periph_selection";
    for (int n = 0; n <= NUM_PERIPH + 2; n++)
    begin
      send(ADDR_MUX, 8'(n));
      check_pins($sformatf("mux %0d cs2_n high", n));
      cs2_n = 1'b0;
      @(negedge clk);
      check_pins($sformatf("mux %0d cs2_n low", n));
      cs2_n = 1'b1;
      @(negedge clk);
      // same value again, reply shows the one-hot select
      send(ADDR_MUX, 8'(n));
    end
    end_test();
  endtask

  task automatic miso_routing();
    logic [7:0] r;
    test_name = "miso_routing";
    // peripheral 2
    send(ADDR_MUX, 8'd3);
    cs2_n = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      rand_bits(NUM_PERIPH, r);
      periph_miso = r[NUM_PERIPH-1:0];
      @(negedge clk);
      if (miso !== r[2])
        mismatch($sformatf("miso with periph_miso %0h", r), r[2], miso);
    end
    cs2_n = 1'b1;
    send(ADDR_LED, 8'h5A);
    // peripherals all high must not leak into the zero bits of the reply
    periph_miso = '1;
    send(ADDR_LED, 8'h00);
    periph_miso = '0;
    end_test();
  endtask

  task automatic short_frames();
    logic [7:0] rx;
    test_name = "short_frames";
    send(ADDR_LED, 8'hC3);
    send(ADDR_ADC, 8'hC3);
    send(ADDR_LED, 8'h50);
    // last 12 bits of an led write setting every bit
    // the value sent just before ends in a zero nibble
    spi_xfer({20'h0, 4'h7, 8'h0F}, 12, rx);
    check_pins("after 12-bit frame");
    // last 16 bits would be a valid led write
    spi_xfer({16'h0, ADDR_LED, 8'h3C}, 20, rx);
    check_pins("after 20-bit frame");
    send(ADDR_LED, 8'h00);
    end_test();
  endtask

  task automatic unknown_address();
    test_name = "unknown_address";
    send(8'h2A, 8'hFF);
    check_pins("after unknown write");
    send(ADDR_MUX, 8'd3);
    send(8'h00, 8'h00);
    end_test();
  endtask

  initial
  begin
    arst_n      = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = '0;
    m_led       = '0;
    m_dac       = '0;
    m_adc       = '0;
    m_sel       = '0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    set_clear_toggle();
    reset_commands();
    periph_selection();
    miso_routing();
    short_frames();
    unknown_address();
    asserts = spi_ctrl_top_inst.spi_ctrl_checker_inst.assert_fails;
    errors += asserts;
    $display("tests %0d, errors %0d, assertion failures %0d", tests, errors, asserts);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== bench/spi_ctrl_checker.sv ====
////////////////////////////////////////////////////////////
// bound assertions on the frame strobe
// and on the peripheral select outputs
////////////////////////////////////////////////////////////

module spi_ctrl_checker #(
  parameter int NUM_PERIPH = 5
) (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  frame_valid,
  input logic [NUM_PERIPH-1:0] sel,
  input logic                  cs2_n,
  input logic [NUM_PERIPH-1:0] periph_cs_n
);

  // failures so far, the testbench adds them to its count
  int unsigned assert_fails = 0;

  // one strobe per cs_n rise
  frame_single: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |=> !frame_valid)
  else
  begin
    assert_fails++;
    $error("frame_valid high in two consecutive cycles");
  end

  // at most one peripheral picked
  sel_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(sel))
  else
  begin
    assert_fails++;
    $error("sel has more than one bit set");
  end

  // chip selects released while the host talks to this block
  cs_idle: assert property (@(posedge clk) disable iff (!arst_n)
    cs2_n |-> &periph_cs_n)
  else
  begin
    assert_fails++;
    $error("periph_cs_n driven low while cs2_n is high");
  end

endmodule

// ==== src/spi_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// board-control block top level
// spi port, control registers, peripheral select, reply mux
////////////////////////////////////////////////////////////

module spi_ctrl_top
  import spi_ctrl_pkg::*;
#(
  parameter int NUM_PERIPH  = 5,
  parameter int SYNC_STAGES = 2
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  sck,
  input  logic                  cs_n,
  input  logic                  mosi,
  input  logic                  cs2_n,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  output logic                  miso,
  output logic [NUM_PERIPH-1:0] periph_cs_n,
  output ctrl_nib_t             led,
  output ctrl_nib_t             dac_ctrl,
  output ctrl_nib_t             adc_ctrl
);

  // port side
  spi_frame_t            frame;
  logic                  frame_valid;
  reg_addr_e             read_addr;
  logic                  read_req;
  logic                  dout;
  logic [7:0]            reply_byte;

  // readback from both parts
  ctrl_nib_t             reg_rd_data;
  logic                  reg_rd_hit;
  logic [7:0]            sel_rd_data;
  logic                  sel_rd_hit;
  logic [NUM_PERIPH-1:0] sel;

  spi_slave_port #(
    .SYNC_STAGES (SYNC_STAGES)
  ) spi_slave_port_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .reply_byte  (reply_byte),
    .frame       (frame),
    .frame_valid (frame_valid),
    .read_addr   (read_addr),
    .read_req    (read_req),
    .dout        (dout)
  );

  ctrl_reg_file ctrl_reg_file_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .read_addr   (read_addr),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .adc_ctrl    (adc_ctrl),
    .rd_data     (reg_rd_data),
    .rd_hit      (reg_rd_hit)
  );

  periph_select #(
    .NUM_PERIPH (NUM_PERIPH)
  ) periph_select_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .read_addr   (read_addr),
    .cs2_n       (cs2_n),
    .sel         (sel),
    .periph_cs_n (periph_cs_n),
    .rd_data     (sel_rd_data),
    .rd_hit      (sel_rd_hit)
  );

  // combinational, feeds the port in the read_req cycle
  bus_response_mux #(
    .NUM_PERIPH (NUM_PERIPH)
  ) bus_response_mux_inst (
    .reg_rd_data (reg_rd_data),
    .reg_rd_hit  (reg_rd_hit),
    .sel_rd_data (sel_rd_data),
    .sel_rd_hit  (sel_rd_hit),
    .sel         (sel),
    .cs2_n       (cs2_n),
    .dout        (dout),
    .periph_miso (periph_miso),
    .reply_byte  (reply_byte),
    .miso        (miso)
  );

endmodule

// ==== src/bus_response_mux.sv ====
////////////////////////////////////////////////////////////
// reply byte merge and miso routing
////////////////////////////////////////////////////////////

module bus_response_mux
  import spi_ctrl_pkg::*;
#(
  parameter int NUM_PERIPH = 5
) (
  input  ctrl_nib_t             reg_rd_data,
  input  logic                  reg_rd_hit,
  input  logic [7:0]            sel_rd_data,
  input  logic                  sel_rd_hit,
  input  logic [NUM_PERIPH-1:0] sel,
  input  logic                  cs2_n,
  input  logic                  dout,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  output logic [7:0]            reply_byte,
  output logic                  miso
);

  logic periph_bit;

  // the two parts own disjoint addresses
  // unknown address reads 0
  always_comb
  begin
    if (reg_rd_hit)
      reply_byte = {4'b0000, reg_rd_data};
    else if (sel_rd_hit)
      reply_byte = sel_rd_data;
    else
      reply_byte = 8'h00;
  end

  // unselected peripherals masked off
  assign periph_bit = |(sel & periph_miso);

  // cs2_n high means the host talks to this block
  assign miso = cs2_n ? dout : periph_bit;

endmodule

// ==== src/periph_select.sv ====
////////////////////////////////////////////////////////////
// one-hot peripheral select register
// chip-select gating by cs2_n and readback
////////////////////////////////////////////////////////////

module periph_select
  import spi_ctrl_pkg::*;
#(
  parameter int NUM_PERIPH = 5
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  spi_frame_t            frame,
  input  logic                  frame_valid,
  input  reg_addr_e             read_addr,
  input  logic                  cs2_n,
  output logic [NUM_PERIPH-1:0] sel,
  output logic [NUM_PERIPH-1:0] periph_cs_n,
  output logic [7:0]            rd_data,
  output logic                  rd_hit
);

  logic [NUM_PERIPH-1:0] sel_dec;

  // value n picks peripheral n-1, 0 and out of range pick nothing
  always_comb
  begin
    for (int i = 0; i < NUM_PERIPH; i++)
      sel_dec[i] = (frame.value == 8'(i + 1));
  end

  // pwrup does not touch the select
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sel <= '0;
    else if (frame_valid && frame.addr == ADDR_MUX)
      sel <= sel_dec;
    else if (frame_valid && frame.addr == ADDR_SOFT_RST)
      sel <= '0;
  end

  // active low, only while the host holds cs2_n low
  assign periph_cs_n = ~(sel & {NUM_PERIPH{~cs2_n}});

  // one-hot vector, zero-extended to the reply byte
  always_comb
  begin
    rd_data = '0;
    rd_data[NUM_PERIPH-1:0] = sel;
  end

  assign rd_hit = (read_addr == ADDR_MUX);

endmodule

// ==== src/ctrl_reg_file.sv ====
////////////////////////////////////////////////////////////
// led, dac and adc control registers
// set/clear/toggle writes, reset commands, readback decode
////////////////////////////////////////////////////////////

module ctrl_reg_file
  import spi_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  spi_frame_t frame,
  input  logic       frame_valid,
  input  reg_addr_e  read_addr,
  output ctrl_nib_t  led,
  output ctrl_nib_t  dac_ctrl,
  output ctrl_nib_t  adc_ctrl,
  output ctrl_nib_t  rd_data,
  output logic       rd_hit
);

  ////////////////////////////////////////////////////////////
  // register writes

  // updates land on the clock after frame_valid
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led      <= '0;
      dac_ctrl <= '0;
      adc_ctrl <= '0;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        ADDR_LED:
          led <= apply_set_clr(led, frame.value);
        ADDR_DAC:
          dac_ctrl <= apply_set_clr(dac_ctrl, frame.value);
        ADDR_ADC:
          adc_ctrl <= apply_set_clr(adc_ctrl, frame.value);
        // command, value byte ignored
        ADDR_SOFT_RST:
        begin
          led      <= '0;
          dac_ctrl <= '0;
          adc_ctrl <= '0;
        end
        // dac left alone here
        ADDR_PWRUP:
        begin
          led      <= '0;
          adc_ctrl <= '0;
        end
        // mux and unknown codes are not ours
        default:
        begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback

  // pure decode, the port captures it in the read_req cycle
  always_comb
  begin
    rd_data = '0;
    rd_hit  = 1'b0;
    case (read_addr)
      ADDR_LED:
      begin
        rd_data = led;
        rd_hit  = 1'b1;
      end
      ADDR_DAC:
      begin
        rd_data = dac_ctrl;
        rd_hit  = 1'b1;
      end
      ADDR_ADC:
      begin
        rd_data = adc_ctrl;
        rd_hit  = 1'b1;
      end
      // commands have nothing to read
      default:
      begin
        rd_data = '0;
        rd_hit  = 1'b0;
      end
    endcase
  end

endmodule

// ==== src/spi_slave_port.sv ====
////////////////////////////////////////////////////////////
// spi slave front end in the clk domain
// synchronizers, edge detect, frame shift-in, reply shift-out
////////////////////////////////////////////////////////////

module spi_slave_port
  import spi_ctrl_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic [7:0] reply_byte,
  output spi_frame_t frame,
  output logic       frame_valid,
  output reg_addr_e  read_addr,
  output logic       read_req,
  output logic       dout
);

  // one spare bit so over-long frames still count past FRAME_BITS
  localparam int CNT_W = $clog2(FRAME_BITS) + 1;
  localparam int BYTE_BITS = FRAME_BITS / 2;
  localparam logic [CNT_W-1:0] CNT_MAX = '1;
  localparam logic [CNT_W-1:0] ADDR_CNT = CNT_W'(BYTE_BITS);
  localparam logic [CNT_W-1:0] FRAME_CNT = CNT_W'(FRAME_BITS);

  // the three host lines move through the synchronizer together
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // mode 0 idle, sck low and chip select released
  localparam spi_pins_t PINS_IDLE = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};

  spi_pins_t             sync_q [SYNC_STAGES];
  spi_pins_t             pins_s;
  logic                  sck_d;
  logic                  cs_n_d;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  cs_rise;
  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] rx_shift;
  logic [7:0]            tx_shift;

  ////////////////////////////////////////////////////////////
  // synchronizer and edge detect

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
        sync_q[i] <= PINS_IDLE;
    end
    else
    begin
      sync_q[0] <= '{sck: sck, cs_n: cs_n, mosi: mosi};
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
    end
  end

  assign pins_s = sync_q[SYNC_STAGES-1];

  // previous sample for edge detect
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sck_d  <= 1'b0;
      cs_n_d <= 1'b1;
    end
    else
    begin
      sck_d  <= pins_s.sck;
      cs_n_d <= pins_s.cs_n;
    end
  end

  // sck edges only count inside a frame
  assign sck_rise = pins_s.sck & ~sck_d & ~pins_s.cs_n;
  assign sck_fall = ~pins_s.sck & sck_d & ~pins_s.cs_n;
  assign cs_rise  = pins_s.cs_n & ~cs_n_d;

  ////////////////////////////////////////////////////////////
  // bit count, shift-in, strobes

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt     <= '0;
      read_req    <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      // 8th bit just sampled, address byte complete
      read_req    <= sck_rise && (bit_cnt == ADDR_CNT - 1'b1);
      // exact length only
      frame_valid <= cs_rise && (bit_cnt == FRAME_CNT);
      if (pins_s.cs_n)
        bit_cnt <= '0;
      else if (sck_rise && bit_cnt != CNT_MAX)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // mosi into lsb, frame builds toward msb
  always_ff @(posedge clk)
  begin
    if (sck_rise)
      rx_shift <= {rx_shift[FRAME_BITS-2:0], pins_s.mosi};
  end

  // hold the finished frame for the consumers
  always_ff @(posedge clk)
  begin
    if (cs_rise)
      frame <= spi_frame_t'(rx_shift);
  end

  // valid in the read_req cycle, lower byte is the address just received
  assign read_addr = reg_addr_e'(rx_shift[BYTE_BITS-1:0]);

  ////////////////////////////////////////////////////////////
  // reply shift-out

  // load on read_req, each falling edge from the 8th on presents the next bit
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tx_shift <= '0;
      dout     <= 1'b0;
    end
    else if (pins_s.cs_n)
    begin
      tx_shift <= '0;
      dout     <= 1'b0;
    end
    else if (read_req)
      tx_shift <= reply_byte;
    else if (sck_fall && bit_cnt >= ADDR_CNT)
    begin
      dout     <= tx_shift[7];
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

endmodule

// ==== src/spi_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types for the spi board-control block
// frame layout, register address codes, control nibble
// and the set/clear/toggle update rule
////////////////////////////////////////////////////////////

package spi_ctrl_pkg;

  // one frame = address byte then value byte, msb first
  localparam int FRAME_BITS = 16;

  // control registers are one nibble wide
  localparam int NIB_W = 4;

  typedef logic [NIB_W-1:0] ctrl_nib_t;

  // address codes seen in the first byte
  typedef enum logic [7:0] {
    // clears led and adc only, dac already configured before rails up
    ADDR_PWRUP    = 8'd6,
    ADDR_LED      = 8'd7,
    ADDR_MUX      = 8'd8,
    ADDR_DAC      = 8'd9,
    // clears everything, select included
    ADDR_SOFT_RST = 8'd11,
    ADDR_ADC      = 8'd14
  } reg_addr_e;

  // addr lands in the upper byte
  typedef struct packed {
    reg_addr_e  addr;
    logic [7:0] value;
  } spi_frame_t;

  // low nibble sets, high nibble clears
  // a bit named in both toggles, the other bits follow set/clear
  function automatic ctrl_nib_t apply_set_clr(ctrl_nib_t cur, logic [7:0] value);
    ctrl_nib_t set_b;
    ctrl_nib_t clr_b;
    ctrl_nib_t tog_b;
    set_b = value[NIB_W-1:0];
    clr_b = value[2*NIB_W-1:NIB_W];
    tog_b = set_b & clr_b;
    // toggled bits come out of the first term as 0, second term inverts
    return ((cur | set_b) & ~clr_b) | (~cur & tog_b);
  endfunction

endpackage
